/* hdl/dmem_pkg.sv */
/*
 * width constants for the data-memory path
 * access size encoding
 * request, memory write-port and response structs
 */
`default_nettype none

package dmem_pkg;

    // datapath geometry
    localparam int XLEN   = 32;           // data and address width
    localparam int NBYTES = XLEN / 8;     // byte lanes per word
    localparam int OFFS_W = 2;            // byte offset inside a word
    localparam int WIDX_W = XLEN - OFFS_W; // word index width

    // access size, same as the low bits of the load/store funct3
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10                   // 2'b11 is reserved, refused by the decoder
    } mem_size_e;

    // core-facing load/store request, one per cycle, no back-pressure
    typedef struct packed {
        logic              valid;         // request present this cycle
        logic              we;            // 1 store, 0 load
        logic [XLEN-1:0]   addr;          // byte address
        logic [XLEN-1:0]   wdata;         // store data, lsb aligned
        mem_size_e         size;
        logic              is_unsigned;   // zero-extend on load
    } mem_req_t;

    // decoded access as the memory array sees it
    typedef struct packed {
        logic [WIDX_W-1:0] widx;          // word index, offset bits dropped
        logic [NBYTES-1:0] be;            // per-lane write enables
        logic [XLEN-1:0]   wdata;         // store data already in its lanes
        logic              re;            // register the addressed word
    } mem_wr_t;

    // response back to the core
    // valid one cycle after a load,
    // or after any refused access
    typedef struct packed {
        logic              valid;
        logic              err;           // misaligned or reserved size
        logic [XLEN-1:0]   rdata;         // extended load data, 0 on err
    } mem_rsp_t;

endpackage

`default_nettype wire

/* hdl/lsu_decode.sv */
/*
 * load/store decoder, purely combinational
 * alignment check, byte enables, lane placement of store data
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_decode (
    input  dmem_pkg::mem_req_t           req,
    output dmem_pkg::mem_wr_t            wr,
    output logic                         ld_valid,
    output logic                         ld_unsigned,
    output logic                         acc_err,
    output logic [dmem_pkg::OFFS_W-1:0]  ld_offset,
    output dmem_pkg::mem_size_e          ld_size
);

    logic [dmem_pkg::OFFS_W-1:0] offset;      // byte position inside the word
    logic                        misaligned;
    logic [dmem_pkg::NBYTES-1:0] size_mask;   // lanes touched, before the shift
    logic [dmem_pkg::XLEN-1:0]   data_mask;   // valid bits of the store data
    logic                        do_store;
    logic                        do_load;

    assign offset = req.addr[dmem_pkg::OFFS_W-1:0];

    // size decides both the legal offsets and the lane footprint
    always_comb begin
        size_mask = '0;
        data_mask = '0;
        case (req.size)
            dmem_pkg::SZ_BYTE: begin
                misaligned     = 1'b0;           // any offset is fine
                size_mask[0]   = 1'b1;
                data_mask[7:0] = '1;
            end
            dmem_pkg::SZ_HALF: begin
                misaligned      = offset[0];     // odd address
                size_mask[1:0]  = 2'b11;
                data_mask[15:0] = '1;
            end
            dmem_pkg::SZ_WORD: begin
                misaligned = (offset != '0);     // must sit on a word boundary
                size_mask  = '1;
                data_mask  = '1;
            end
            default: begin
                misaligned = 1'b1;               // reserved size, treat as a bad access
            end
        endcase
    end

    // a refused access must not write nor read
    assign do_store = req.valid & req.we & ~misaligned;
    assign do_load  = req.valid & ~req.we & ~misaligned;

    // memory side
    assign wr.widx  = req.addr[dmem_pkg::XLEN-1:dmem_pkg::OFFS_W];
    assign wr.be    = do_store ? (size_mask << offset) : '0;
    // store data moved up by offset bytes
    // a byte lands in lane offset, a half in offset and offset+1
    assign wr.wdata = (req.wdata & data_mask) << {offset, 3'b000};
    assign wr.re    = do_load;

    // load info for the extender, taken with the read
    assign ld_valid    = do_load;
    assign ld_unsigned = req.is_unsigned;
    assign ld_offset   = offset;
    assign ld_size     = req.size;

    // flagged for loads and stores alike
    assign acc_err = req.valid & misaligned;

endmodule

`default_nettype wire

/* hdl/data_mem.sv */
/*
 * word-organised data memory
 * per-byte write enables, registered word read
 */
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int MEM_WORDS = 256           // depth in words, power of two
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  dmem_pkg::mem_wr_t             wr,
    output logic [dmem_pkg::XLEN-1:0]     rdata_word
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    // storage, one packed byte vector per word
    logic [dmem_pkg::NBYTES-1:0][7:0] mem [MEM_WORDS];

    logic [IDX_W-1:0] idx;   // word index modulo depth

    // upper index bits are dropped, so addresses past the depth wrap
    assign idx = wr.widx[IDX_W-1:0];

    // byte-lane writes on the rising edge
    // the request is sampled at this same edge
    always_ff @(posedge clk) begin
        for (int i = 0; i < dmem_pkg::NBYTES; i++) begin
            if (wr.be[i]) begin
                mem[idx][i] <= wr.wdata[8*i +: 8];   // only enabled lanes change
            end
        end
    end

    // read port
    // word is registered, so data shows up one cycle after the request;
    // a write at the same address in that cycle is not seen here yet
    // (old word comes back)
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_word <= '0;
        end else if (wr.re) begin
            rdata_word <= mem[idx];                  // whole word, extender picks bytes
        end
    end

endmodule

`default_nettype wire

/* hdl/load_extend.sv */
/*
 * load extender
 * holds the load controls for one cycle, then picks the
 * addressed byte or half and sign- or zero-extends it
 */
`timescale 1ns/1ps
`default_nettype none

module load_extend (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ld_valid,
    input  logic                          ld_unsigned,
    input  logic                          acc_err,
    input  logic [dmem_pkg::OFFS_W-1:0]   ld_offset,
    input  dmem_pkg::mem_size_e           ld_size,
    input  logic [dmem_pkg::XLEN-1:0]     rdata_word,
    output dmem_pkg::mem_rsp_t            rsp
);

    // control that travels alongside the registered memory read
    typedef struct packed {
        logic                        valid;       // aligned load in flight
        logic                        err;         // refused access in flight
        logic                        is_unsigned;
        logic [dmem_pkg::OFFS_W-1:0] offset;
        dmem_pkg::mem_size_e         size;
    } ld_ctl_t;

    ld_ctl_t                   ctl_q;
    logic [dmem_pkg::XLEN-1:0] shifted;    // addressed byte moved to lane 0
    logic                      sign_b;
    logic                      sign_h;
    logic [dmem_pkg::XLEN-1:0] ext_data;

    // same edge as the memory read register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctl_q <= '0;
        end else begin
            ctl_q.valid       <= ld_valid;
            ctl_q.err         <= acc_err;     // loads and stores both report
            ctl_q.is_unsigned <= ld_unsigned;
            ctl_q.offset      <= ld_offset;
            ctl_q.size        <= ld_size;
        end
    end

    assign shifted = rdata_word >> {ctl_q.offset, 3'b000};

    // fill bit, 0 when unsigned
    assign sign_b = ~ctl_q.is_unsigned & shifted[7];
    assign sign_h = ~ctl_q.is_unsigned & shifted[15];

    always_comb begin
        case (ctl_q.size)
            dmem_pkg::SZ_BYTE: ext_data = {{(dmem_pkg::XLEN-8){sign_b}}, shifted[7:0]};
            dmem_pkg::SZ_HALF: ext_data = {{(dmem_pkg::XLEN-16){sign_h}}, shifted[15:0]};
            default:           ext_data = rdata_word;   // word passes straight through
        endcase
    end

    // one-cycle response, data forced to zero on error
    assign rsp.valid = ctl_q.valid | ctl_q.err;
    assign rsp.err   = ctl_q.err;
    assign rsp.rdata = ctl_q.err ? '0 : ext_data;

endmodule

`default_nettype wire

/* hdl/dmem_top.sv */
/*
 * data-memory top level
 * decoder, byte-lane memory and load extender wired in a row
 */
`timescale 1ns/1ps
`default_nettype none

module dmem_top #(
    parameter int MEM_WORDS = 256            // passed down to the array
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dmem_pkg::mem_req_t   req,        // one request per cycle
    output dmem_pkg::mem_rsp_t   rsp         // one cycle after the request
);

    dmem_pkg::mem_wr_t            wr;         // decoded write/read port
    logic                         ld_valid;
    logic                         ld_unsigned;
    logic                         acc_err;
    logic [dmem_pkg::OFFS_W-1:0]  ld_offset;
    dmem_pkg::mem_size_e          ld_size;
    logic [dmem_pkg::XLEN-1:0]    rdata_word; // raw word from the array

    // combinational decode of the incoming request
    lsu_decode u_decode (
        .req         (req),
        .wr          (wr),
        .ld_valid    (ld_valid),
        .ld_unsigned (ld_unsigned),
        .acc_err     (acc_err),
        .ld_offset   (ld_offset),
        .ld_size     (ld_size)
    );

    // byte-lane storage
    data_mem #(
        .MEM_WORDS   (MEM_WORDS)
    ) u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (wr),
        .rdata_word  (rdata_word)
    );

    // lines the controls up with the read and builds rsp
    load_extend u_extend (
        .clk         (clk),
        .rst_n       (rst_n),
        .ld_valid    (ld_valid),
        .ld_unsigned (ld_unsigned),
        .acc_err     (acc_err),
        .ld_offset   (ld_offset),
        .ld_size     (ld_size),
        .rdata_word  (rdata_word),
        .rsp         (rsp)
    );

endmodule

`default_nettype wire

/* testbench/tb_dmem_top.sv */
/*
 * testbench for dmem_top
 * replays load/store vectors from a text file and checks every response
 * one line per test and a closing count line at the end
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dmem_top;

    localparam int MEM_WORDS  = 64;          // small array so aliasing is easy to reach
    localparam int RST_CYCLES = 16;
    localparam int IDLE_START = 4;           // quiet cycles checked right after reset
    localparam int MARGIN     = 64;          // gaps, start-up idle and drain
    localparam int MAX_VEC    = 256;

    logic               clk = 1'b0;
    logic               rst_n;
    dmem_pkg::mem_req_t req;
    dmem_pkg::mem_rsp_t rsp;

    // vector table filled once at time 0
    int                        n_vec;
    int                        v_test  [MAX_VEC];
    logic                      v_we    [MAX_VEC];
    logic [1:0]                v_size  [MAX_VEC];
    logic                      v_uns   [MAX_VEC];
    logic [dmem_pkg::XLEN-1:0] v_addr  [MAX_VEC];
    logic [dmem_pkg::XLEN-1:0] v_wdata [MAX_VEC];
    logic [dmem_pkg::XLEN-1:0] v_rdata [MAX_VEC];
    logic                      v_err   [MAX_VEC];

    integer seed        = 32'h3c9e;
    int     cycles      = 0;
    int     cycle_limit = RST_CYCLES + MARGIN;   // raised once the vectors are known
    int     checks      = 0;
    int     errors      = 0;
    int     n_tests     = 0;
    int     test_errs   = 0;
    int     test_vecs   = 0;

    // access whose response is due at the next falling edge
    logic pend;
    int   pend_idx;

    dmem_top #(
        .MEM_WORDS (MEM_WORDS)
    ) u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp)
    );

    always #2 clk = ~clk;   // 4 ns period

    // run-length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // reads testbench/dmem_input.txt into the vector table
    task automatic load_vectors();
        int                fd;
        int                cnt;
        int                t;
        logic [8*128-1:0]  line;       // one text line, right aligned
        logic [31:0]       f_we;
        logic [31:0]       f_size;
        logic [31:0]       f_uns;
        logic [31:0]       f_addr;
        logic [31:0]       f_wdata;
        logic [31:0]       f_rdata;
        logic [31:0]       f_err;
        n_vec = 0;
        fd = $fopen("testbench/dmem_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file testbench/dmem_input.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // a # line scans no field and is skipped
                cnt = $sscanf(line, "%d %h %h %h %h %h %h %h",
                              t, f_we, f_size, f_uns, f_addr, f_wdata, f_rdata, f_err);
                if (cnt == 8 && n_vec < MAX_VEC) begin
                    v_test[n_vec]  = t;
                    v_we[n_vec]    = f_we[0];
                    v_size[n_vec]  = f_size[1:0];
                    v_uns[n_vec]   = f_uns[0];
                    v_addr[n_vec]  = f_addr;
                    v_wdata[n_vec] = f_wdata;
                    v_rdata[n_vec] = f_rdata;
                    v_err[n_vec]   = f_err[0];
                    n_vec++;
                end else if (cnt > 0) begin
                    $display("vector line could not be read: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic note_error();
        errors++;
        test_errs++;
    endtask

    // closes a test line once its last access was checked
    task automatic close_test(input int i);
        test_vecs++;
        if (i == n_vec - 1 || v_test[i+1] != v_test[i]) begin
            $display("test %0d: %0d accesses, %0d errors", v_test[i], test_vecs, test_errs);
            n_tests++;
            test_vecs = 0;
            test_errs = 0;
        end
    endtask

    // compares rsp against the expected columns of vector i
    task automatic check_access(input int i);
        logic expect_rsp;
        expect_rsp = !v_we[i] || v_err[i];   // loads and refused stores answer
        checks++;
        if (expect_rsp) begin
            if (rsp.valid !== 1'b1) begin
                $display("test %0d vector %0d: rsp.valid missing one cycle after the access",
                         v_test[i], i);
                note_error();
            end else begin
                if (rsp.err !== v_err[i]) begin
                    $display("ERR rsp.err expected %h got %h (test %0d vector %0d)",
                             v_err[i], rsp.err, v_test[i], i);
                    note_error();
                end
                if (rsp.rdata !== v_rdata[i]) begin
                    $display("ERR rsp.rdata expected %h got %h (test %0d vector %0d)",
                             v_rdata[i], rsp.rdata, v_test[i], i);
                    note_error();
                end
            end
        end else if (rsp.valid !== 1'b0) begin
            $display("test %0d vector %0d: rsp.valid raised by an aligned store",
                     v_test[i], i);
            note_error();
        end
        close_test(i);
    endtask

    // called on every falling edge where rsp is registered and stable
    task automatic check_response();
        if (pend) begin
            check_access(pend_idx);
            pend = 1'b0;
        end else begin
            checks++;
            if (rsp.valid !== 1'b0) begin
                $display("rsp.valid high with no access in flight at cycle %0d", cycles);
                note_error();
            end
        end
    endtask

    task automatic drive_idle();
        req  = '0;
        pend = 1'b0;
    endtask

    task automatic drive_access(input int i);
        req.valid       = 1'b1;
        req.we          = v_we[i];
        req.addr        = v_addr[i];
        req.wdata       = v_wdata[i];
        req.size        = dmem_pkg::mem_size_e'(v_size[i]);
        req.is_unsigned = v_uns[i];
        pend            = 1'b1;   // checked on the next falling edge
        pend_idx        = i;
    endtask

    initial begin
        int gap;
        int idx;
        rst_n = 1'b0;
        req   = '0;
        pend  = 1'b0;
        load_vectors();
        cycle_limit = 2 * n_vec + RST_CYCLES + MARGIN;
        if (n_vec == 0) begin
            $display("vector file holds no usable vectors");
            errors++;
        end

        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;   // released on a falling edge

        // nothing may answer while req.valid stays low
        repeat (IDLE_START) begin
            @(negedge clk);
            check_response();
        end
        $display("idle after reset: %0d cycles, %0d errors", IDLE_START, test_errs);
        test_errs = 0;

        for (idx = 0; idx < n_vec; idx++) begin
            // random gap only between tests while accesses inside a test run back to back
            if (idx > 0 && v_test[idx] != v_test[idx-1]) begin
                gap = $unsigned($random(seed)) % 3;
                repeat (gap) begin
                    @(negedge clk);
                    check_response();
                    drive_idle();
                end
            end
            @(negedge clk);
            check_response();   // previous access first
            drive_access(idx);
        end

        // drain the last response and check one more quiet cycle
        @(negedge clk);
        check_response();
        drive_idle();
        @(negedge clk);
        check_response();

        $display("done: %0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/dmem_input.txt */
# test we size uns addr wdata exp_rdata exp_err  (test in decimal, the rest in hex)
# size 0 byte 1 half 2 word, exp_rdata is don't-care for stores without error
1 1 2 0 00000000 11223344 00000000 0
1 0 2 0 00000000 00000000 11223344 0
1 1 2 0 00000004 a5a5f00f 00000000 0
1 1 2 0 000000fc deadbeef 00000000 0
1 0 2 0 00000004 00000000 a5a5f00f 0
1 0 2 0 000000fc 00000000 deadbeef 0
2 1 2 0 00000010 01020304 00000000 0
2 1 0 0 00000011 000000aa 00000000 0
2 0 2 0 00000010 00000000 0102aa04 0
2 1 0 0 00000013 12345655 00000000 0
2 0 2 0 00000010 00000000 5502aa04 0
2 1 1 0 00000012 ffffbeef 00000000 0
2 0 2 0 00000010 00000000 beefaa04 0
2 1 1 0 00000010 00007788 00000000 0
2 0 2 0 00000010 00000000 beef7788 0
2 1 0 0 00000010 ffffffc3 00000000 0
2 0 2 0 00000010 00000000 beef77c3 0
2 1 2 0 00000014 ffffffff 00000000 0
2 1 0 0 00000014 00000000 00000000 0
2 1 1 0 00000016 00001234 00000000 0
2 0 2 0 00000014 00000000 1234ff00 0
3 1 2 0 00000020 80f17f01 00000000 0
3 1 2 0 00000024 7ffe8000 00000000 0
3 0 0 0 00000020 00000000 00000001 0
3 0 0 0 00000021 00000000 0000007f 0
3 0 0 0 00000022 00000000 fffffff1 0
3 0 0 0 00000023 00000000 ffffff80 0
3 0 0 1 00000020 00000000 00000001 0
3 0 0 1 00000021 00000000 0000007f 0
3 0 0 1 00000022 00000000 000000f1 0
3 0 0 1 00000023 00000000 00000080 0
3 0 1 0 00000020 00000000 00007f01 0
3 0 1 0 00000022 00000000 ffff80f1 0
3 0 1 1 00000020 00000000 00007f01 0
3 0 1 1 00000022 00000000 000080f1 0
3 0 1 0 00000024 00000000 ffff8000 0
3 0 1 1 00000024 00000000 00008000 0
3 0 1 0 00000026 00000000 00007ffe 0
3 0 0 0 00000025 00000000 ffffff80 0
4 1 2 0 00000030 cafef00d 00000000 0
4 1 1 0 00000031 00001111 00000000 1
4 1 1 0 00000033 00002222 00000000 1
4 1 2 0 00000031 33333333 00000000 1
4 1 2 0 00000032 44444444 00000000 1
4 1 2 0 00000033 55555555 00000000 1
4 0 1 0 00000031 00000000 00000000 1
4 0 1 1 00000033 00000000 00000000 1
4 0 2 0 00000032 00000000 00000000 1
4 0 2 0 00000030 00000000 cafef00d 0
4 0 1 0 00000032 00000000 ffffcafe 0
5 1 2 0 00000040 10203040 00000000 0
5 1 2 0 00000044 50607080 00000000 0
5 1 2 0 00000048 90a0b0c0 00000000 0
5 1 2 0 0000004c d0e0f000 00000000 0
5 0 2 0 0000004c 00000000 d0e0f000 0
5 0 2 0 00000040 00000000 10203040 0
5 0 0 0 00000047 00000000 00000050 0
5 0 1 0 0000004a 00000000 ffff90a0 0
5 0 2 0 00000044 00000000 50607080 0
5 0 0 1 0000004d 00000000 000000f0 0
5 0 1 1 0000004e 00000000 0000d0e0 0
6 1 2 0 00000100 0badf00d 00000000 0
6 0 2 0 00000000 00000000 0badf00d 0
6 1 0 0 000002ff 0000005a 00000000 0
6 0 2 0 000000fc 00000000 5aadbeef 0
6 0 2 0 000001fc 00000000 5aadbeef 0
6 0 1 1 00004006 00000000 0000a5a5 0
6 0 2 0 ffffff00 00000000 0badf00d 0
7 0 2 0 00000010 00000000 beef77c3 0
7 1 2 0 00000010 00000000 00000000 0
7 0 2 0 00000010 00000000 00000000 0
7 0 0 0 00000013 00000000 00000000 0

/* filelist.f */
hdl/dmem_pkg.sv
hdl/lsu_decode.sv
hdl/data_mem.sv
hdl/load_extend.sv
hdl/dmem_top.sv
testbench/tb_dmem_top.sv
